/* dv/tb_tasks.svh */
////////////////////
// Directed tests, compare task,
// LCG and download drive helpers
////////////////////

function logic [31:0] lcg_next();
	rnd_state = rnd_state * 32'd1664525 + 32'd1013904223;
	return rnd_state;
endfunction

task automatic compare(input string what, input logic [127:0] got, input logic [127:0] exp);
	check_cnt++;
	if (got !== exp) begin
		$display("error at %0t ns: %s got %0h, expected %0h", $time, what, got, exp);
		err_cnt++;
	end
endtask

task automatic end_test(input string name, input int e0);
	tests_run++;
	$display("test %s done, %0d errors", name, err_cnt - e0);
endtask

//////////////////// Loader side
// All called on a falling edge
task automatic dl_begin(input logic [7:0] index);
	dl.index  = index;
	dl.active = 1'b1;
	dl.wr     = 1'b0;
	@(negedge clk_sys);
endtask

task automatic dl_write(input logic [`CART_DL_ADDR_W-1:0] addr, input logic [15:0] data);
	while (dl_wait) begin
		dl.wr = 1'b0;   // Held off
		@(negedge clk_sys);
	end
	dl.wr   = 1'b1;
	dl.addr = addr;
	dl.data = data;
	@(negedge clk_sys);
	dl.wr = 1'b0;
endtask

task automatic dl_finish();
	dl.active = 1'b0;
	dl.wr     = 1'b0;
	repeat (2) @(negedge clk_sys);
endtask

task automatic send_rom_words(input logic [`CART_DL_ADDR_W-1:0] base, input int n,
	output logic [`CART_DL_ADDR_W-1:0] last);
	logic [`CART_DL_ADDR_W-1:0] a;
	logic [31:0]                r;
	cart_pkg::rom_word_t        w;
	a = base;
	for (int i = 0; i < n; i++) begin
		r      = lcg_next();
		w.addr = a[`CART_DL_ADDR_W-1:1];   // Byte address / 2
		w.data = {r[23:16], r[31:24]};     // Bytes swapped
		exp_q.push_back(w);
		dl_write(a, r[31:16]);
		last = a;
		a    = a + 25'd2;
	end
endtask

task automatic wait_rom_writes(input int n);
	int cycles;
	cycles = 0;
	while ((wr_log.size() < n || mem_req != mem_ack) && cycles < n * 40 + 100) begin
		@(negedge clk_sys);
		cycles++;
	end
	if (wr_log.size() < n || mem_req != mem_ack) begin
		$display("ROM writes did not complete in time, %0d of %0d seen", wr_log.size(), n);
		err_cnt++;
	end
endtask

task automatic verify_rom_log();
	compare("ROM write count", 128'(wr_log.size()), 128'(exp_q.size()));
	foreach (exp_q[i]) begin
		if (i < wr_log.size())
			compare($sformatf("ROM write %0d", i), 128'(wr_log[i]), 128'(exp_q[i]));
		compare($sformatf("ROM array at %0h", exp_q[i].addr),
			128'(rom_mem[exp_q[i].addr[9:0]]), 128'(exp_q[i].data));
	end
endtask

task automatic send_header(input logic [7:0] index, input logic [15:0] word_a,
	input logic [15:0] word_b);
	dl_begin(index);
	dl_write(`HDR_REGION_A, word_a);
	dl_write(`HDR_REGION_B, word_b);
	dl_write(`HDR_END_A, 16'h0000);
endtask

task automatic expect_region(input string what, input cart_pkg::region_e exp_reg,
	input logic exp_set);
	compare({what, " region"}, 128'(region), 128'(exp_reg));
	compare({what, " region_set"}, 128'(region_set), 128'(exp_set));
	dl_finish();
	compare({what, " region_set after end"}, 128'(region_set), 128'(1'b0));
endtask

//////////////////// Tests
task automatic reset_state();
	int e0;
	e0 = err_cnt;
	compare("dl_wait", 128'(dl_wait), 128'(1'b0));
	compare("mem_req", 128'(mem_req), 128'(1'b0));
	compare("code_valid", 128'(code_valid), 128'(1'b0));
	compare("code_clear", 128'(code_clear), 128'(1'b0));
	compare("region_set", 128'(region_set), 128'(1'b0));
	end_test("reset_state", e0);
endtask

task automatic rom_path();
	int                         e0;
	logic [`CART_DL_ADDR_W-1:0] last;
	e0 = err_cnt;
	wr_log.delete();
	exp_q.delete();
	dl_begin(8'h00);
	send_rom_words(25'h000400, ROM_WORDS, last);
	dl_finish();
	wait_rom_writes(ROM_WORDS);
	verify_rom_log();
	compare("ROM size", 128'(rom_size), 128'(last));
	end_test("rom_path", e0);
endtask

task automatic back_pressure();
	int                         e0;
	logic [`CART_DL_ADDR_W-1:0] last;
	e0 = err_cnt;
	wr_log.delete();
	exp_q.delete();
	force_stall = 1'b1;   // Each write takes 30 cycles
	wait_seen   = 1'b0;
	dl_begin(8'h00);
	send_rom_words(25'h000800, ROM_WORDS, last);
	dl_finish();
	wait_rom_writes(ROM_WORDS);
	force_stall = 1'b0;
	compare("dl_wait seen high", 128'(wait_seen), 128'(1'b1));
	verify_rom_log();
	compare("ROM size", 128'(rom_size), 128'(last));
	end_test("back_pressure", e0);
endtask

task automatic region_priority();
	int e0;
	e0 = err_cnt;
	auto_mode = 2'd0;
	prio      = 2'd1;   // EU>US>JP
	send_header(8'h00, 16'h2055, 16'h2045);   // U at 0x1F0, E at 0x1F2
	expect_region("prio 1", cart_pkg::REGION_EU, 1'b1);
	prio = 2'd0;        // US>EU>JP
	send_header(8'h00, 16'h2055, 16'h2045);
	expect_region("prio 0", cart_pkg::REGION_US, 1'b1);
	prio = 2'd1;
	send_header(8'h00, 16'h2020, 16'h2020);   // No flags
	expect_region("no flags prio 1", cart_pkg::REGION_EU, 1'b1);
	prio = 2'd2;
	send_header(8'h00, 16'h2020, 16'h2020);
	expect_region("no flags prio 2", cart_pkg::REGION_US, 1'b1);
	end_test("region_priority", e0);
endtask

task automatic country_code();
	int e0;
	e0 = err_cnt;
	auto_mode = 2'd0;
	prio      = 2'd3;   // JP>US>EU
	// Digit 5 is 0101, J and U
	send_header(8'h00, 16'h2035, 16'h2020);
	expect_region("code 5", cart_pkg::REGION_JP, 1'b1);
	// Letter C, 0x43 - 7 has low nibble 1100, U and E
	send_header(8'h00, 16'h2043, 16'h2020);
	expect_region("code C", cart_pkg::REGION_US, 1'b1);
	auto_mode = 2'd1;   // File extension
	send_header(8'h80, 16'h2020, 16'h2020);
	expect_region("index 80", cart_pkg::REGION_EU, 1'b1);
	send_header(8'h00, 16'h2020, 16'h2020);
	expect_region("index 00", cart_pkg::REGION_JP, 1'b0);
	auto_mode = 2'd0;
	end_test("country_code", e0);
endtask

task automatic cheat_codes();
	int                    e0;
	int                    k;
	logic [15:0]           w [8];
	logic [31:0]           r;
	cart_pkg::cheat_code_t exp_code;
	e0 = err_cnt;
	dl_begin(`CODE_INDEX);
	for (k = 0; k < 8; k++) begin
		r    = lcg_next();
		w[k] = r[31:16];
		dl_write(25'(2 * k), w[k]);   // Offsets 0 to 14
		compare($sformatf("code_clear after offset %0d", 2 * k), 128'(code_clear), 128'(k == 0));
		compare($sformatf("code_valid after offset %0d", 2 * k), 128'(code_valid), 128'(k == 7));
	end
	// Low word first in each field
	exp_code.flags   = {w[1], w[0]};
	exp_code.addr    = {w[3], w[2]};
	exp_code.compare = {w[5], w[4]};
	exp_code.replace = {w[7], w[6]};
	compare("cheat code", 128'(code), 128'(exp_code));
	dl_finish();
	end_test("cheat_codes", e0);
endtask

/* dv/tb_cart_loader.sv */
////////////////////
// Cartridge loader testbench
// Clock, reset, ROM memory model, watchdog
////////////////////
`timescale 1ns/1ps
`include "cart_macros.svh"

module tb_cart_loader;

	localparam int ROM_WORDS = 40;
	// Cycle budget: reset, two ROM downloads, header and cheat tests, margin
	localparam int WATCHDOG_CYCLES = 16 + ROM_WORDS * 12 + ROM_WORDS * 36 + 16 * 20 + 600;

	logic                       clk_sys = 1'b0;
	logic                       RESET;
	cart_pkg::dl_port_t         dl;
	logic                       dl_wait;
	logic [1:0]                 auto_mode;
	logic [1:0]                 prio;
	cart_pkg::rom_word_t        mem;
	logic                       mem_req;
	logic                       mem_ack = 1'b0;
	logic [`CART_DL_ADDR_W-1:0] rom_size;
	cart_pkg::cheat_code_t      code;
	logic                       code_valid;
	logic                       code_clear;
	cart_pkg::region_e          region;
	logic                       region_set;

	// Memory model state and bookkeeping
	logic [31:0]         rnd_state = 32'h24c5_b93a;
	logic [15:0]         rom_mem [1024];
	cart_pkg::rom_word_t wr_log [$];     // Writes in arrival order
	cart_pkg::rom_word_t exp_q [$];
	logic                mem_busy = 1'b0;
	int                  mem_cnt = 0;
	logic                force_stall = 1'b0;
	logic                wait_seen = 1'b0;
	int                  err_cnt = 0;
	int                  check_cnt = 0;
	int                  tests_run = 0;

	`include "tb_tasks.svh"

	always #4 clk_sys = ~clk_sys;   // 8 ns period

	cart_loader_top dut_i (
		.clk_sys(clk_sys), .RESET(RESET), .dl(dl), .dl_wait(dl_wait),
		.auto_mode(auto_mode), .prio(prio),
		.mem(mem), .mem_req(mem_req), .mem_ack(mem_ack), .rom_size(rom_size),
		.code(code), .code_valid(code_valid), .code_clear(code_clear),
		.region(region), .region_set(region_set)
	);

	//////////////////// ROM memory
	// Takes each new toggle, answers after 0 to 7 cycles or a forced stall
	always @(negedge clk_sys) begin
		if (RESET) begin
			mem_ack  = 1'b0;
			mem_busy = 1'b0;
			mem_cnt  = 0;
		end else if (mem_busy) begin
			mem_cnt = mem_cnt - 1;
			if (mem_cnt == 0) begin
				mem_ack  = mem_req;   // Write complete
				mem_busy = 1'b0;
			end
		end else if (mem_req != mem_ack) begin
			wr_log.push_back(mem);
			rom_mem[mem.addr[9:0]] = mem.data;
			mem_cnt = force_stall ? 30 : int'((lcg_next() >> 16) & 32'h7);
			if (mem_cnt == 0)
				mem_ack = mem_req;
			else
				mem_busy = 1'b1;
		end
	end

	always @(negedge clk_sys)
		if (dl_wait)
			wait_seen = 1'b1;

	//////////////////// Test sequence
	initial begin
		RESET     = 1'b1;
		dl        = '0;
		auto_mode = 2'd0;
		prio      = 2'd0;
		repeat (16) @(negedge clk_sys);
		RESET = 1'b0;
		repeat (2) @(negedge clk_sys);
		reset_state();
		rom_path();
		back_pressure();
		region_priority();
		country_code();
		cheat_codes();
		$display("%0d tests, %0d checks, %0d errors", tests_run, check_cnt, err_cnt);
		if (err_cnt == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

	// Hang guard
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		$display("watchdog expired, tests did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Something failed");
		$finish;
	end

endmodule

/* run.sh */
#!/bin/sh
# Build the cartridge loader testbench with Verilator, run it and look for the pass line

verilator --binary --timing --assert -f sim.f --top-module tb_cart_loader -o tb_cart_loader \
	&& ./obj_dir/tb_cart_loader | tee /dev/stderr | grep -x "Everything OK" > /dev/null \
	|| { echo "simulation run did not pass" >&2; exit 1; }

/* sim.f */
+incdir+src
+incdir+dv
src/cart_pkg.sv
src/dl_decoder.sv
src/hdr_region.sv
src/word_queue.sv
src/rom_writer.sv
src/cart_loader_top.sv
dv/tb_cart_loader.sv

/* src/cart_loader_top.sv */
////////////////////
// Cartridge loader top
////////////////////
`timescale 1ns/1ps
`include "cart_macros.svh"

module cart_loader_top (
	input  logic                       clk_sys,
	input  logic                       RESET,
	input  cart_pkg::dl_port_t         dl,
	output logic                       dl_wait,
	input  logic [1:0]                 auto_mode,
	input  logic [1:0]                 prio,
	output cart_pkg::rom_word_t        mem,
	output logic                       mem_req,
	input  logic                       mem_ack,
	output logic [`CART_DL_ADDR_W-1:0] rom_size,
	output cart_pkg::cheat_code_t      code,
	output logic                       code_valid,
	output logic                       code_clear,
	output cart_pkg::region_e          region,
	output logic                       region_set
);

	logic                push;
	cart_pkg::rom_word_t push_word;
	logic                pop;
	cart_pkg::rom_word_t head;
	logic                empty;

	//////////////////// Producer side
	dl_decoder dl_decoder_i (
		.clk_sys(clk_sys), .RESET(RESET), .dl(dl),
		.push(push), .push_word(push_word),
		.code(code), .code_valid(code_valid), .code_clear(code_clear),
		.rom_size(rom_size)
	);

	hdr_region hdr_region_i (
		.clk_sys(clk_sys), .RESET(RESET), .dl(dl),
		.auto_mode(auto_mode), .prio(prio),
		.region(region), .region_set(region_set)
	);

	// Near-full holds the loader off
	word_queue word_queue_i (
		.clk_sys(clk_sys), .RESET(RESET),
		.push(push), .push_word(push_word), .pop(pop),
		.head(head), .empty(empty), .near_full(dl_wait)
	);

	//////////////////// Memory side
	rom_writer rom_writer_i (
		.clk_sys(clk_sys), .RESET(RESET),
		.head(head), .empty(empty), .pop(pop),
		.mem(mem), .mem_req(mem_req), .mem_ack(mem_ack)
	);

endmodule

/* src/cart_macros.svh */
////////////////////
// Widths, header addresses, queue depth
// and cheat code word offsets
////////////////////
`ifndef CART_MACROS_SVH
`define CART_MACROS_SVH

`define CART_ADDR_W     24                  // ROM word address, byte address without bit 0
`define CART_DL_ADDR_W  (`CART_ADDR_W + 1)  // Download byte address
`define CART_DATA_W     16
`define CART_INDEX_W    8
`define CART_Q_DEPTH    8

// Cartridge header
`define HDR_REGION_A    25'h1F0
`define HDR_REGION_B    25'h1F2
`define HDR_END_A       25'h200

// Cheat download
`define CODE_INDEX      8'hFF
`define CODE_FIELD_W    32
`define CODE_OFS_FLG_L  4'd0
`define CODE_OFS_FLG_H  4'd2
`define CODE_OFS_ADR_L  4'd4
`define CODE_OFS_ADR_H  4'd6
`define CODE_OFS_CMP_L  4'd8
`define CODE_OFS_CMP_H  4'd10
`define CODE_OFS_REP_L  4'd12
`define CODE_OFS_REP_H  4'd14

`endif

/* src/cart_pkg.sv */
////////////////////
// Download port, ROM word and cheat code
// types, console region codes
////////////////////
`include "cart_macros.svh"

package cart_pkg;

	// Loader download port
	typedef struct packed {
		logic                         active;
		logic                         wr;
		logic [`CART_DL_ADDR_W-1:0]   addr;   // Byte address
		logic [`CART_DATA_W-1:0]      data;
		logic [`CART_INDEX_W-1:0]     index;  // File index
	} dl_port_t;

	// One ROM memory write
	typedef struct packed {
		logic [`CART_ADDR_W-1:0]      addr;   // Word address
		logic [`CART_DATA_W-1:0]      data;   // Already byte swapped
	} rom_word_t;

	typedef struct packed {
		logic [`CODE_FIELD_W-1:0]     flags;
		logic [`CODE_FIELD_W-1:0]     addr;
		logic [`CODE_FIELD_W-1:0]     compare;
		logic [`CODE_FIELD_W-1:0]     replace;
	} cheat_code_t;

	typedef enum logic [1:0] {
		REGION_JP = 2'd0,
		REGION_US = 2'd1,
		REGION_EU = 2'd2
	} region_e;

endpackage

/* src/dl_decoder.sv */
////////////////////
// Download decoder
// ROM word forming, cheat code assembly, ROM size
////////////////////
`timescale 1ns/1ps
`include "cart_macros.svh"

module dl_decoder (
	input  logic                       clk_sys,
	input  logic                       RESET,
	input  cart_pkg::dl_port_t         dl,
	output logic                       push,
	output cart_pkg::rom_word_t        push_word,
	output cart_pkg::cheat_code_t      code,
	output logic                       code_valid,
	output logic                       code_clear,
	output logic [`CART_DL_ADDR_W-1:0] rom_size
);

	logic                       code_dl;
	logic                       cart_dl;
	logic                       cart_q;     // cart_dl one cycle late
	logic [`CART_DL_ADDR_W-1:0] last_addr;
	logic [3:0]                 ofs;

	assign code_dl = dl.active && (dl.index == `CODE_INDEX);
	assign cart_dl = dl.active && (dl.index != `CODE_INDEX);
	assign ofs     = dl.addr[3:0];

	//////////////////// ROM path
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			push <= 1'b0;
		end else begin
			push <= cart_dl & dl.wr;
		end
	end

	// Word address and swapped bytes
	always_ff @(posedge clk_sys) begin
		push_word.addr <= dl.addr[`CART_DL_ADDR_W-1:1];
		push_word.data <= {dl.data[7:0], dl.data[15:8]};
		if (cart_dl && dl.wr)
			last_addr <= dl.addr;
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cart_q   <= 1'b0;
			rom_size <= '0;
		end else begin
			cart_q <= cart_dl;
			if (cart_q && !cart_dl)
				rom_size <= last_addr;   // End of cartridge download
		end
	end

	//////////////////// Cheat codes
	always_ff @(posedge clk_sys) begin
		if (code_dl && dl.wr) begin
			case (ofs)
				`CODE_OFS_FLG_L: code.flags[15:0]    <= dl.data;
				`CODE_OFS_FLG_H: code.flags[31:16]   <= dl.data;
				`CODE_OFS_ADR_L: code.addr[15:0]     <= dl.data;
				`CODE_OFS_ADR_H: code.addr[31:16]    <= dl.data;
				`CODE_OFS_CMP_L: code.compare[15:0]  <= dl.data;
				`CODE_OFS_CMP_H: code.compare[31:16] <= dl.data;
				`CODE_OFS_REP_L: code.replace[15:0]  <= dl.data;
				`CODE_OFS_REP_H: code.replace[31:16] <= dl.data;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			code_valid <= 1'b0;
			code_clear <= 1'b0;
		end else begin
			code_valid <= code_dl && dl.wr && (ofs == `CODE_OFS_REP_H);  // Last slice
			code_clear <= code_dl && dl.wr && (ofs == `CODE_OFS_FLG_L);
		end
	end

	// Loader protocol
	a_wr_in_active: assert property (@(posedge clk_sys) disable iff (RESET)
		dl.wr |-> dl.active)
		else $error("download write while not active");

endmodule

/* src/hdr_region.sv */
////////////////////
// Header region scan
// J/U/E flags and region choice
////////////////////
`timescale 1ns/1ps
`include "cart_macros.svh"

module hdr_region (
	input  logic                clk_sys,
	input  logic                RESET,
	input  cart_pkg::dl_port_t  dl,
	input  logic [1:0]          auto_mode,  // 0 header, 1 file extension, 2 disabled
	input  logic [1:0]          prio,       // Region priority order
	output cart_pkg::region_e   region,
	output logic                region_set
);

	logic       cart_dl;
	logic       cart_q;
	logic       hdr_wr;
	logic [2:0] hdr_flags;   // Indexed by region code
	logic [2:0] flags_nxt;
	logic [2:0] lo_mask;
	logic [2:0] hi_mask;
	logic       lo_digit;
	logic       lo_hex;
	logic [3:0] cc_val;

	// Region letter to flag bit
	function automatic logic [2:0] letter_mask(input logic [7:0] ch);
		case (ch)
			"J":     return 3'b001;
			"U":     return 3'b010;
			"E":     return 3'b100;
			default: return 3'b000;
		endcase
	endfunction

	function automatic cart_pkg::region_e pick_region(input logic [1:0] sel,
		input logic [2:0] flags);
		cart_pkg::region_e ord [3];
		case (sel)
			2'd0:    ord = '{cart_pkg::REGION_US, cart_pkg::REGION_EU, cart_pkg::REGION_JP};
			2'd1:    ord = '{cart_pkg::REGION_EU, cart_pkg::REGION_US, cart_pkg::REGION_JP};
			2'd2:    ord = '{cart_pkg::REGION_US, cart_pkg::REGION_JP, cart_pkg::REGION_EU};
			default: ord = '{cart_pkg::REGION_JP, cart_pkg::REGION_US, cart_pkg::REGION_EU};
		endcase
		if (flags[ord[0]]) return ord[0];
		if (flags[ord[1]]) return ord[1];
		if (flags[ord[2]]) return ord[2];
		return ord[0];   // No flag, first in order
	endfunction

	assign cart_dl  = dl.active && (dl.index != `CODE_INDEX);
	assign hdr_wr   = cart_dl && dl.wr;
	assign lo_mask  = letter_mask(dl.data[7:0]);
	assign hi_mask  = letter_mask(dl.data[15:8]);
	assign lo_digit = (dl.data[7:0] >= "0") && (dl.data[7:0] <= "9");
	assign lo_hex   = (dl.data[7:0] >= "A") && (dl.data[7:0] <= "F");
	assign cc_val   = lo_digit ? dl.data[3:0] : dl.data[3:0] - 4'd7;

	//////////////////// Flag update
	always_comb begin
		flags_nxt = hdr_flags;
		if (cart_dl && !cart_q)
			flags_nxt = '0;                              // New cartridge
		if (hdr_wr && dl.addr == `HDR_REGION_A) begin
			if (|lo_mask)
				flags_nxt = flags_nxt | lo_mask;
			else if (lo_digit || lo_hex)
				flags_nxt = {cc_val[3], cc_val[2], cc_val[0]};  // Country code
			flags_nxt = flags_nxt | hi_mask;
		end
		if (hdr_wr && dl.addr == `HDR_REGION_B)
			flags_nxt = flags_nxt | lo_mask;
	end

	//////////////////// Region choice
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cart_q     <= 1'b0;
			hdr_flags  <= '0;
			region     <= cart_pkg::REGION_JP;
			region_set <= 1'b0;
		end else begin
			cart_q    <= cart_dl;
			hdr_flags <= flags_nxt;
			if (hdr_wr && dl.addr == `HDR_END_A) begin
				case (auto_mode)
					2'd0: begin
						region     <= pick_region(prio, hdr_flags);
						region_set <= 1'b1;
					end
					2'd1: begin
						region     <= cart_pkg::region_e'(dl.index[7:6]);
						region_set <= |dl.index;
					end
					default: ;   // Disabled
				endcase
			end
			if (cart_q && !cart_dl)
				region_set <= 1'b0;
		end
	end

endmodule

/* src/rom_writer.sv */
////////////////////
// ROM writer that drains the word queue
// over the toggle req/ack pair
////////////////////
`timescale 1ns/1ps

module rom_writer (
	input  logic                 clk_sys,
	input  logic                 RESET,
	input  cart_pkg::rom_word_t  head,
	input  logic                 empty,
	output logic                 pop,
	output cart_pkg::rom_word_t  mem,
	output logic                 mem_req,
	input  logic                 mem_ack
);

	logic busy;

	// Outstanding while levels differ
	assign busy = (mem_req != mem_ack);
	assign pop  = !busy && !empty;

	always_ff @(posedge clk_sys) begin
		if (pop)
			mem <= head;   // Held until ack
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			mem_req <= 1'b0;
		end else if (pop) begin
			mem_req <= ~mem_req;   // Start write
		end
	end

	// Memory only ever answers an outstanding write
	a_ack_follows_req: assert property (@(posedge clk_sys) disable iff (RESET)
		(mem_ack != $past(mem_ack)) |-> (mem_ack == mem_req))
		else $error("ROM acknowledge changed without a pending write");

endmodule

/* src/word_queue.sv */
////////////////////
// Show-ahead ROM word FIFO
// with near-full level
////////////////////
`timescale 1ns/1ps
`include "cart_macros.svh"

module word_queue (
	input  logic                 clk_sys,
	input  logic                 RESET,
	input  logic                 push,
	input  cart_pkg::rom_word_t  push_word,
	input  logic                 pop,
	output cart_pkg::rom_word_t  head,
	output logic                 empty,
	output logic                 near_full
);

	localparam int PTR_W = $clog2(`CART_Q_DEPTH);
	localparam int CNT_W = $clog2(`CART_Q_DEPTH + 1);

	cart_pkg::rom_word_t q_mem [`CART_Q_DEPTH];
	logic [PTR_W-1:0]    wr_ptr;
	logic [PTR_W-1:0]    rd_ptr;
	logic [CNT_W-1:0]    count;
	logic                full;

	assign head      = q_mem[rd_ptr];   // Show-ahead
	assign empty     = (count == '0);
	assign full      = (count == CNT_W'(`CART_Q_DEPTH));
	assign near_full = (count >= CNT_W'(`CART_Q_DEPTH - 2));  // One word may be in flight

	always_ff @(posedge clk_sys) begin
		if (push)
			q_mem[wr_ptr] <= push_word;
	end

	//////////////////// Pointers
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: ;   // Both or none
			endcase
		end
	end

	// Producer must see near_full in time
	a_no_overflow: assert property (@(posedge clk_sys) disable iff (RESET)
		push |-> (!full || pop))
		else $error("word queue push while full");

	a_no_underflow: assert property (@(posedge clk_sys) disable iff (RESET)
		pop |-> !empty)
		else $error("word queue pop while empty");

endmodule
